//--- fetch_pair.sv
`default_nettype none

`include "ifetch_macros.svh"

module fetch_pair import ifetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic load,		// capture both words into an empty pair
	input logic consume0,	// queue took slot0
	input logic consume1,	// queue took slot1
	input logic flush,		// drop everything on a branch miss
	input address_t pc,
	input instruction_t inst0,
	input instruction_t inst1,
	output fetch_pair_t pair
);

	logic v0;
	logic v1;
	address_t pc0;
	address_t pc1;
	instruction_t ins0;
	instruction_t ins1;

	// flush wins over load and consume
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			v0 <= 1'b0;
			v1 <= 1'b0;
		end else if (flush) begin
			v0 <= 1'b0;
			v1 <= 1'b0;
		end else if (load) begin
			v0 <= 1'b1;
			v1 <= 1'b1;
		end else begin
			if (consume0)
				v0 <= 1'b0;
			if (consume1)
				v1 <= 1'b0;
		end
	end

	// payload only changes on a load
	always_ff @(posedge clk) begin
		if (load) begin
			pc0 <= pc;
			pc1 <= pc + address_t'(`SLOT_STEP);	// second word of the line
			ins0 <= inst0;
			ins1 <= inst1;
		end
	end

	always_comb begin
		pair.slot0 = '{v0, pc0, ins0};
		pair.slot1 = '{v1, pc1, ins1};
	end

	// a fill on top of live words would lose instructions
	a_load_when_empty: assert property (
		@(posedge clk) disable iff (rst)
		load |-> (!v0 && !v1)
	) else $error("pair loaded while not empty");

	// the queue can only take what is presented as valid
	a_consume_valid: assert property (
		@(posedge clk) disable iff (rst)
		(!consume0 || v0) && (!consume1 || v1)
	) else $error("consume of an invalid slot");

endmodule

`default_nettype wire

//--- fetch_pc.sv
`default_nettype none

`include "ifetch_macros.svh"

module fetch_pc import ifetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic fetch,		// a pair takes the words at pc this edge
	input logic irq,		// interrupt pending, hold the pc
	input logic branchmiss,	// redirect strobe
	input address_t misspc,
	output address_t pc
);

	// redirect beats everything, then the sequential step
	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			pc <= `RESET_PC;
		else if (branchmiss)
			pc <= misspc;	// restart on the correct path
		else if (fetch && !irq)
			pc <= pc + address_t'(`FETCH_STEP);	// two words consumed from the cache line
	end

	// instructions are word sized, so the fetch address must stay aligned
	// through both the sequential path and every redirect from the backend
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (rst)
		pc[1:0] == 2'b00
	) else $error("pc lost word alignment");

	// the steering never fills a pair in the cycle it flushes
	a_no_fetch_on_miss: assert property (
		@(posedge clk) disable iff (rst)
		!(fetch && branchmiss)
	) else $error("fetch together with branchmiss");

endmodule

`default_nettype wire

//--- fetch_steer.sv
`default_nettype none

`include "ifetch_macros.svh"

module fetch_steer import ifetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic hit,		// cache has the words for pc
	input logic branchmiss,
	input logic iq_free0,	// first queue entry free
	input logic iq_free1,	// second queue entry free
	input fetch_pair_t pair_ab,
	input fetch_pair_t pair_cd,
	output logic load_ab,
	output logic load_cd,
	output logic flush,
	output logic consume_a0,
	output logic consume_a1,
	output logic consume_c0,
	output logic consume_c1,
	output logic fetch,		// either pair loads, pc steps
	output fetch_slot_t fetch0,	// older presented instruction
	output fetch_slot_t fetch1	// younger presented instruction
);

	logic sel;			// 0 presents A/B, 1 presents C/D
	fetch_pair_t cur;	// pair facing the queue
	logic ab_empty;
	logic cd_empty;
	logic take0;		// queue takes the presented slot0
	logic take1;		// queue takes the presented slot1
	logic flip;			// presented pair drained, move to the other

	always_comb begin
		cur = sel ? pair_cd : pair_ab;
		ab_empty = !pair_ab.slot0.v && !pair_ab.slot1.v;
		cd_empty = !pair_cd.slot0.v && !pair_cd.slot1.v;
	end

	// enqueue table, as seen from the presented pair
	// slot0 pairs with free0, slot1 with free1 unless slot0 is gone
	always_comb begin
		take0 = 1'b0;
		take1 = 1'b0;
		flip = 1'b0;
		if (!branchmiss) begin
			case ({cur.slot0.v, cur.slot1.v})
				2'b11: begin
					take0 = iq_free0;
					take1 = iq_free0 && iq_free1;	// both go, pair drained
					flip = iq_free0 && iq_free1;
				end
				2'b10: begin
					take0 = iq_free0;	// lone older word
					flip = iq_free0;
				end
				2'b01: begin
					take1 = iq_free0;	// leftover word takes the first entry
					flip = iq_free0;
				end
				default: ;	// nothing presented
			endcase
		end
	end

	// fill only on a hit, A/B first, nothing while flushing
	always_comb begin
		load_ab = hit && !branchmiss && ab_empty;
		load_cd = hit && !branchmiss && !ab_empty && cd_empty;
		fetch = load_ab || load_cd;
		flush = branchmiss;
	end

	// route the decisions to the presented pair only
	always_comb begin
		consume_a0 = take0 && !sel;
		consume_a1 = take1 && !sel;
		consume_c0 = take0 && sel;
		consume_c1 = take1 && sel;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			sel <= 1'b0;
		else if (branchmiss)
			sel <= 1'b0;	// everything flushed, restart at A/B
		else if (load_ab && cd_empty)
			sel <= 1'b0;	// refill from nothing, A/B holds the oldest words
		else if (flip)
			sel <= ~sel;
	end

	always_comb begin
		fetch0 = cur.slot0;
		fetch1 = cur.slot1;
	end

	// the queue fills its entries in order
	a_iq_free_order: assert property (
		@(posedge clk) disable iff (rst)
		!(iq_free1 && !iq_free0)
	) else $error("iq_free1 without iq_free0");

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
ifetch_pkg.sv
fetch_pc.sv
fetch_pair.sv
fetch_steer.sv
ifetch_top.sv
tb_ifetch.sv

//--- ifetch_macros.svh
`ifndef IFETCH_MACROS_SVH
`define IFETCH_MACROS_SVH

// datapath widths
`define ADDR_W 32
`define INSTR_W 32

// boot vector, first fetch after reset
`define RESET_PC 32'hFFFD0000

// byte distance from word 0 to word 1 of one fetch
`define SLOT_STEP 4

// pc advance per two-word fetch
`define FETCH_STEP 8

`endif

//--- ifetch_pkg.sv
`default_nettype none

`include "ifetch_macros.svh"

package ifetch_pkg;

	typedef logic [`ADDR_W-1:0] address_t;		// byte address of a fetch
	typedef logic [`INSTR_W-1:0] instruction_t;	// raw instruction word

	// one buffered instruction, v marks it as live
	typedef struct packed {
		logic v;
		address_t pc;
		instruction_t instr;
	} fetch_slot_t;

	// one buffer pair, slot0 is the older word
	typedef struct packed {
		fetch_slot_t slot0;
		fetch_slot_t slot1;
	} fetch_pair_t;

endpackage

`default_nettype wire

//--- ifetch_top.sv
`default_nettype none

`include "ifetch_macros.svh"

module ifetch_top import ifetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic hit,
	input logic irq,
	input logic branchmiss,
	input address_t misspc,
	input instruction_t inst0,
	input instruction_t inst1,
	input logic iq_free0,
	input logic iq_free1,
	output address_t pc,
	output fetch_slot_t fetch0,
	output fetch_slot_t fetch1
);

	fetch_pair_t pair_ab;
	fetch_pair_t pair_cd;
	logic load_ab;
	logic load_cd;
	logic flush;
	logic consume_a0;
	logic consume_a1;
	logic consume_c0;
	logic consume_c1;
	logic fetch;
	logic fetch_ok;	// cache hit and no interrupt pending

	// with the pc held no pair may fill, or the same words would go in twice
	assign fetch_ok = hit && !irq;

	fetch_pc fetch_pc_i (
		.clk(clk),
		.rst(rst),
		.fetch(fetch),
		.irq(irq),
		.branchmiss(branchmiss),
		.misspc(misspc),
		.pc(pc)
	);

	fetch_steer fetch_steer_i (
		.clk(clk),
		.rst(rst),
		.hit(fetch_ok),
		.branchmiss(branchmiss),
		.iq_free0(iq_free0),
		.iq_free1(iq_free1),
		.pair_ab(pair_ab),
		.pair_cd(pair_cd),
		.load_ab(load_ab),
		.load_cd(load_cd),
		.flush(flush),
		.consume_a0(consume_a0),
		.consume_a1(consume_a1),
		.consume_c0(consume_c0),
		.consume_c1(consume_c1),
		.fetch(fetch),
		.fetch0(fetch0),
		.fetch1(fetch1)
	);

	fetch_pair pair_ab_i (
		.clk(clk),
		.rst(rst),
		.load(load_ab),
		.consume0(consume_a0),
		.consume1(consume_a1),
		.flush(flush),
		.pc(pc),
		.inst0(inst0),
		.inst1(inst1),
		.pair(pair_ab)
	);

	fetch_pair pair_cd_i (
		.clk(clk),
		.rst(rst),
		.load(load_cd),
		.consume0(consume_c0),
		.consume1(consume_c1),
		.flush(flush),
		.pc(pc),
		.inst0(inst0),
		.inst1(inst1),
		.pair(pair_cd)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench, exit status is the verdict
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_ifetch -f filelist.f -o tb_ifetch_sim
./obj_dir/tb_ifetch_sim

//--- tb_ifetch.sv
`default_nettype none

`include "ifetch_macros.svh"

module tb_ifetch import ifetch_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int RUN_CYCLES = 2000;
	localparam int MAX_CYCLES = RESET_CYCLES + RUN_CYCLES;	// run ends here
	// minimum event counts over the run
	localparam int MIN_DOUBLE = 100;
	localparam int MIN_SINGLE = 100;
	localparam int MIN_MISS = 30;
	localparam int MIN_STALL = 50;
	localparam int MIN_IRQ_HOLD = 20;

	logic clk = 1'b0;
	logic rst;
	logic hit;
	logic irq;
	logic branchmiss;
	address_t misspc;
	instruction_t inst0;
	instruction_t inst1;
	logic iq_free0;
	logic iq_free1;
	address_t pc;
	fetch_slot_t fetch0;
	fetch_slot_t fetch1;

	integer seed;
	int cycle = 0;
	address_t exp_pc;		// next pc the queue must receive
	logic take0;			// queue takes fetch0 at this edge
	logic take1;			// queue takes fetch1 at this edge
	instruction_t word0;	// memory word at fetch0.pc
	instruction_t word1;
	int n_double = 0;
	int n_single = 0;
	int n_miss = 0;
	int n_stall = 0;
	int n_irq_hold = 0;

	// instruction memory contents, every bit of the address feeds the word
	function automatic instruction_t mem_word(input address_t a);
		logic [31:0] x;
		x = a ^ 32'h3c6e_f372;
		x = x * 32'h9e37_79b1;
		x = x ^ {x[15:0], x[31:16]};
		return instruction_t'(x ^ a);
	endfunction

	function automatic bit coverage_met();
		return n_double >= MIN_DOUBLE && n_single >= MIN_SINGLE && n_miss >= MIN_MISS &&
			n_stall >= MIN_STALL && n_irq_hold >= MIN_IRQ_HOLD;
	endfunction

	task automatic abort_run(input string msg);
		$display("Fail at time %0t: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1, "stopping on the first error");
	endtask

	always #20 clk = ~clk;	// 40 unit period

	// cache read port, words follow pc within the cycle
	assign inst0 = mem_word(pc);
	assign inst1 = mem_word(pc + address_t'(`SLOT_STEP));

	ifetch_top ifetch_top_i (
		.clk(clk),
		.rst(rst),
		.hit(hit),
		.irq(irq),
		.branchmiss(branchmiss),
		.misspc(misspc),
		.inst0(inst0),
		.inst1(inst1),
		.iq_free0(iq_free0),
		.iq_free1(iq_free1),
		.pc(pc),
		.fetch0(fetch0),
		.fetch1(fetch1)
	);

	initial begin : stimulus
		logic [31:0] r;
		logic [31:0] r2;
		int gap;		// cycles to the next branch miss
		seed = 32'hf748;
		rst = 1'b1;
		hit = 1'b0;
		irq = 1'b0;
		branchmiss = 1'b0;
		misspc = '0;
		iq_free0 = 1'b0;
		iq_free1 = 1'b0;
		gap = 40;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		forever begin
			r = $random(seed);
			r2 = $random(seed);
			hit <= r[1:0] != 2'b00;		// three in four
			irq <= r[6:3] == 4'h0;
			iq_free0 <= r[9:8] != 2'b00;
			iq_free1 <= r[9:8] != 2'b00 && r[10];	// never without iq_free0
			if (gap == 0) begin
				branchmiss <= 1'b1;
				misspc <= {r2[31:2], 2'b00};	// word aligned target
				gap = 32 + int'(r[15:12]);
			end else begin
				branchmiss <= 1'b0;
				gap = gap - 1;
			end
			@(posedge clk);
		end
	end

	// consumption as the queue sees it, nothing is taken while flushing
	always_comb begin
		take0 = !branchmiss && fetch0.v && iq_free0;
		take1 = !branchmiss && fetch1.v && (fetch0.v ? iq_free1 : iq_free0);
		word0 = mem_word(fetch0.pc);
		word1 = mem_word(fetch1.pc);
	end

	// program order model and event counters
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (rst)
			exp_pc <= `RESET_PC;
		else if (branchmiss)
			exp_pc <= misspc;
		else if (take0 && take1)
			exp_pc <= exp_pc + address_t'(2 * `SLOT_STEP);
		else if (take0 || take1)
			exp_pc <= exp_pc + address_t'(`SLOT_STEP);
		if (!rst) begin
			if (take0 && take1)
				n_double <= n_double + 1;
			if (take0 != take1)
				n_single <= n_single + 1;
			if (branchmiss)
				n_miss <= n_miss + 1;
			if (!iq_free0 && !branchmiss && (fetch0.v || fetch1.v))
				n_stall <= n_stall + 1;
			if (irq && hit && !branchmiss)
				n_irq_hold <= n_irq_hold + 1;	// pc must not move here
		end
	end

	a_reset_state: assert property (@(posedge clk)
		($past(rst) && !rst) |-> (pc == `RESET_PC && !fetch0.v && !fetch1.v)
	) else abort_run("wrong pc or valid slot right after reset");

	a_word0: assert property (@(posedge clk) disable iff (rst)
		fetch0.v |-> fetch0.instr == word0
	) else abort_run("fetch0 instr does not match memory");

	a_word1: assert property (@(posedge clk) disable iff (rst)
		fetch1.v |-> fetch1.instr == word1
	) else abort_run("fetch1 instr does not match memory");

	// both presented slots always come from one fetch
	a_pair_pc: assert property (@(posedge clk) disable iff (rst)
		(fetch0.v && fetch1.v) |-> fetch1.pc == fetch0.pc + address_t'(`SLOT_STEP)
	) else abort_run("fetch1 pc is not fetch0 pc plus one word");

	a_order0: assert property (@(posedge clk) disable iff (rst)
		take0 |-> fetch0.pc == exp_pc
	) else abort_run("fetch0 consumed out of program order");

	a_order1: assert property (@(posedge clk) disable iff (rst)
		take1 |-> fetch1.pc == (take0 ? exp_pc + address_t'(`SLOT_STEP) : exp_pc)
	) else abort_run("fetch1 consumed out of program order");

	a_pc_step: assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && !$past(branchmiss)) |->
			(pc == $past(pc) ||
			(pc == $past(pc) + address_t'(`FETCH_STEP) && !$past(irq)))
	) else abort_run("pc moved by a wrong step or while irq was high");

	a_miss: assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && $past(branchmiss)) |->
			(pc == $past(misspc) && !fetch0.v && !fetch1.v)
	) else abort_run("no redirect or flush after branchmiss");

	// a stalled queue leaves the presented pair alone
	a_hold: assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && $past(!iq_free0 && !iq_free1 && !branchmiss && (fetch0.v || fetch1.v)))
			|-> (fetch0 == $past(fetch0) && fetch1 == $past(fetch1))
	) else abort_run("presented slots changed under back-pressure");

	initial begin
		wait (cycle >= MAX_CYCLES);
		@(negedge clk);
		if (coverage_met()) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("missing coverage: double %0d single %0d miss %0d stall %0d irq %0d",
				n_double, n_single, n_miss, n_stall, n_irq_hold);
			$display("Result: FAILED");
			$fatal(1, "run ended without reaching every event minimum");
		end
	end

endmodule

`default_nettype wire
